// File: design/core_shell_defs.svh
// CSR shell constants: machine-mode CSR address map, mstatus fields and counter width

`ifndef CORE_SHELL_DEFS_SVH
`define CORE_SHELL_DEFS_SVH

//////////////////////////////
// CSR address map
//////////////////////////////

// Machine status, trap pc and trap cause
`define CSR_MSTATUS     12'h300
`define CSR_MEPC        12'h341
`define CSR_MCAUSE      12'h342

// Data memory event counters, read and write
`define CSR_MCNT_LOAD   12'hB03
`define CSR_MCNT_STORE  12'hB04

//////////////////////////////
// mstatus fields
//////////////////////////////

// Global machine interrupt enable
`define MSTATUS_MIE_BIT   3
// Enable saved on trap entry
`define MSTATUS_MPIE_BIT  7

// Width of each event counter
`define PERF_CNT_W  32

`endif

// File: design/core_shell_pkg.sv
// Shared types of the CSR shell: data widths, CSR operations and grouped port bundles

`default_nettype none

package core_shell_pkg;

  //////////////////////////////
  // Plain vector types
  //////////////////////////////

  // Data and pc word
  typedef logic [31:0] word_t;
  // CSR address space
  typedef logic [11:0] csr_addr_t;
  // Trap cause, bit 5 marks an interrupt
  typedef logic [5:0]  exc_cause_t;

  // CSR read-modify-write operation
  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  //////////////////////////////
  // Port bundles
  //////////////////////////////

  // CSR access from the execute stage
  typedef struct packed {
    logic    access;
    csr_op_e op;
    word_t   operand_a;   // Write data
    word_t   operand_b;   // Low 12 bits hold the address
  } ex_csr_req_t;

  // CSR access from the debug unit
  typedef struct packed {
    logic      req;
    logic      we;
    csr_addr_t addr;
    word_t     wdata;
  } dbg_csr_req_t;

  // Trap save and restore strobes from the controller
  typedef struct packed {
    logic       save_cause;
    logic       save_id;
    logic       save_if;
    logic       restore_mret;
    exc_cause_t cause;
    word_t      pc_if;
    word_t      pc_id;
  } trap_ctrl_t;

  // Observed data memory handshake
  typedef struct packed {
    logic req;
    logic gnt;
    logic we;
  } data_bus_mon_t;

  // Busy levels of the pipeline stages
  typedef struct packed {
    logic if_busy;
    logic ctrl_busy;
    logic lsu_busy;
    logic load_event;   // Load waiting on an event
    logic firstfetch;   // Controller still in its first fetch
  } stage_busy_t;

endpackage

`default_nettype wire

// File: design/perf_counters.sv
// Data memory load and store event counters, readable and writable through the CSR port

`default_nettype none

`include "core_shell_defs.svh"

module perf_counters import core_shell_pkg::*; (
  input  logic          clk,
  input  logic          rst_ni,
  input  data_bus_mon_t bus_i,
  input  logic          we_i,
  input  csr_addr_t     addr_i,
  input  word_t         wdata_i,
  output word_t         rdata_o,
  output logic          hit_o
);

  logic                   load_ev;
  logic                   store_ev;
  logic [`PERF_CNT_W-1:0] cnt_load_q;
  logic [`PERF_CNT_W-1:0] cnt_store_q;

  //////////////////////////////
  // Event detection
  //////////////////////////////

  // Granted request split by direction
  assign load_ev  = bus_i.req & bus_i.gnt & ~bus_i.we;
  assign store_ev = bus_i.req & bus_i.gnt & bus_i.we;

  //////////////////////////////
  // Counters
  //////////////////////////////

  // CSR write beats a same-cycle increment
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_load_q  <= '0;
      cnt_store_q <= '0;
    end else begin
      if (we_i && (addr_i == `CSR_MCNT_LOAD)) begin
        cnt_load_q <= wdata_i[`PERF_CNT_W-1:0];
      end else if (load_ev) begin
        cnt_load_q <= cnt_load_q + `PERF_CNT_W'(1);
      end
      if (we_i && (addr_i == `CSR_MCNT_STORE)) begin
        cnt_store_q <= wdata_i[`PERF_CNT_W-1:0];
      end else if (store_ev) begin
        cnt_store_q <= cnt_store_q + `PERF_CNT_W'(1);
      end
    end
  end

  // Read port whose hit selects this source in the CSR read mux
  always_comb begin
    rdata_o = '0;
    hit_o   = 1'b0;
    case (addr_i)
      `CSR_MCNT_LOAD: begin
        rdata_o = word_t'(cnt_load_q);
        hit_o   = 1'b1;
      end
      `CSR_MCNT_STORE: begin
        rdata_o = word_t'(cnt_store_q);
        hit_o   = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: design/csr_file.sv
// Machine-mode CSR file with debug/execute request merge, trap save and mret restore

`default_nettype none

`include "core_shell_defs.svh"

module csr_file import core_shell_pkg::*; (
  input  logic          clk,
  input  logic          rst_ni,
  input  ex_csr_req_t   ex_csr_i,
  input  dbg_csr_req_t  dbg_csr_i,
  input  trap_ctrl_t    trap_i,
  input  data_bus_mon_t bus_i,
  output word_t         rdata_o,
  output logic          m_irq_enable_o,
  output word_t         mepc_o
);

  // Effective request after the merge
  csr_op_e    csr_op;
  csr_addr_t  csr_addr;
  word_t      csr_wdata;
  logic       csr_we;
  word_t      csr_wdata_int;

  // Read sources
  word_t      csr_rdata_int;
  word_t      cnt_rdata;
  logic       cnt_hit;

  // Machine-mode state
  logic       mie_q;
  logic       mie_d;
  logic       mpie_q;
  logic       mpie_d;
  word_t      mepc_q;
  word_t      mepc_d;
  exc_cause_t mcause_q;
  exc_cause_t mcause_d;

  //////////////////////////////
  // Request merge
  //////////////////////////////

  // Debug wins, and a debug access is only write or read
  assign csr_op    = dbg_csr_i.req ? (dbg_csr_i.we ? CSR_OP_WRITE : CSR_OP_NONE)
                                   : ex_csr_i.op;
  assign csr_addr  = dbg_csr_i.req ? dbg_csr_i.addr
                                   : (ex_csr_i.access ? ex_csr_i.operand_b[11:0] : '0);
  assign csr_wdata = dbg_csr_i.req ? dbg_csr_i.wdata : ex_csr_i.operand_a;

  assign csr_we = (csr_op != CSR_OP_NONE);

  // New value from the old one
  always_comb begin
    case (csr_op)
      CSR_OP_WRITE: csr_wdata_int = csr_wdata;
      CSR_OP_SET:   csr_wdata_int = rdata_o | csr_wdata;
      CSR_OP_CLEAR: csr_wdata_int = rdata_o & ~csr_wdata;
      default:      csr_wdata_int = rdata_o;
    endcase
  end

  //////////////////////////////
  // Read mux
  //////////////////////////////

  always_comb begin
    csr_rdata_int = '0;
    case (csr_addr)
      `CSR_MSTATUS: begin
        csr_rdata_int[`MSTATUS_MIE_BIT]  = mie_q;
        csr_rdata_int[`MSTATUS_MPIE_BIT] = mpie_q;
      end
      `CSR_MEPC:   csr_rdata_int = mepc_q;
      // Interrupt flag lives in the top bit
      `CSR_MCAUSE: csr_rdata_int = {mcause_q[5], 26'b0, mcause_q[4:0]};
      default: ;
    endcase
  end

  // Unknown addresses fall through as zero
  assign rdata_o = cnt_hit ? cnt_rdata : csr_rdata_int;

  //////////////////////////////
  // Next state
  //////////////////////////////

  always_comb begin
    mie_d    = mie_q;
    mpie_d   = mpie_q;
    mepc_d   = mepc_q;
    mcause_d = mcause_q;

    // Software or debug write
    if (csr_we) begin
      case (csr_addr)
        `CSR_MSTATUS: begin
          mie_d  = csr_wdata_int[`MSTATUS_MIE_BIT];
          mpie_d = csr_wdata_int[`MSTATUS_MPIE_BIT];
        end
        `CSR_MEPC:   mepc_d   = {csr_wdata_int[31:1], 1'b0};
        `CSR_MCAUSE: mcause_d = {csr_wdata_int[31], csr_wdata_int[4:0]};
        default: ;
      endcase
    end

    // Trap entry overrides the write and takes the ID pc first
    if (trap_i.save_id) begin
      mepc_d = {trap_i.pc_id[31:1], 1'b0};
    end else if (trap_i.save_if) begin
      mepc_d = {trap_i.pc_if[31:1], 1'b0};
    end

    if (trap_i.save_cause) begin
      mcause_d = trap_i.cause;
      mpie_d   = mie_q;
      mie_d    = 1'b0;
    end

    // Return from trap
    if (trap_i.restore_mret) begin
      mie_d  = mpie_q;
      mpie_d = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      mie_q    <= 1'b0;
      mpie_q   <= 1'b0;
      mepc_q   <= '0;
      mcause_q <= '0;
    end else begin
      mie_q    <= mie_d;
      mpie_q   <= mpie_d;
      mepc_q   <= mepc_d;
      mcause_q <= mcause_d;
    end
  end

  assign m_irq_enable_o = mie_q;
  assign mepc_o         = mepc_q;

  //////////////////////////////
  // Counters
  //////////////////////////////

  perf_counters perf_counters_inst (
    .clk     (clk),
    .rst_ni  (rst_ni),
    .bus_i   (bus_i),
    .we_i    (csr_we),
    .addr_i  (csr_addr),
    .wdata_i (csr_wdata_int),
    .rdata_o (cnt_rdata),
    .hit_o   (cnt_hit)
  );

  // Controller never enters and leaves a trap in one cycle
  assert property (@(posedge clk) disable iff (!rst_ni)
    !(trap_i.save_cause && trap_i.restore_mret))
    else $error("trap save and mret restore in the same cycle");

  // Execute stage flags an access only with a real operation
  assert property (@(posedge clk) disable iff (!rst_ni)
    ex_csr_i.access |-> (ex_csr_i.op != CSR_OP_NONE))
    else $error("execute CSR access without an operation");

endmodule

`default_nettype wire

// File: design/busy_tracker.sv
// Registered core-busy with first-fetch override, plus clock enable and sleep level

`default_nettype none

module busy_tracker import core_shell_pkg::*; (
  input  logic        clk,
  input  logic        rst_ni,
  input  stage_busy_t busy_i,
  input  logic        bus_req_i,
  input  logic        debug_busy_i,
  input  logic        clock_en_req_i,
  input  logic        fetch_enable_i,
  output logic        core_busy_o,
  output logic        clock_en_o,
  output logic        sleeping_o
);

  logic core_busy_int;
  logic core_busy_q;

  //////////////////////////////
  // Busy register
  //////////////////////////////

  // While a load waits on an event only the fetch side keeps the core busy
  assign core_busy_int = (busy_i.load_event & bus_req_i)
                       ? busy_i.if_busy
                       : (busy_i.if_busy | busy_i.ctrl_busy | busy_i.lsu_busy);

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      core_busy_q <= 1'b0;
    end else begin
      core_busy_q <= core_busy_int;
    end
  end

  // Forced busy until the first fetch has gone out
  assign core_busy_o = busy_i.firstfetch | core_busy_q;

  //////////////////////////////
  // Clock enable and sleep
  //////////////////////////////

  assign clock_en_o = clock_en_req_i | core_busy_o | debug_busy_i;

  // Idle with fetch switched off
  assign sleeping_o = ~fetch_enable_i & ~core_busy_o;

endmodule

`default_nettype wire

// File: design/core_shell.sv
// Core control shell top: CSR file with debug merge and counters, busy and clock-enable logic

`default_nettype none

module core_shell import core_shell_pkg::*; (
  input  logic          clk,
  input  logic          rst_ni,

  // CSR requests
  input  ex_csr_req_t   ex_csr_i,
  input  dbg_csr_req_t  dbg_csr_i,
  output word_t         csr_rdata_o,

  // Trap control and interrupt state
  input  trap_ctrl_t    trap_i,
  output logic          m_irq_enable_o,
  output word_t         mepc_o,

  // Data memory monitor
  input  data_bus_mon_t bus_i,

  // Busy and power control
  input  stage_busy_t   busy_i,
  input  logic          debug_busy_i,
  input  logic          clock_en_req_i,
  input  logic          fetch_enable_i,
  output logic          core_busy_o,
  output logic          clock_en_o,
  output logic          sleeping_o
);

  //////////////////////////////
  // CSR file
  //////////////////////////////

  // Counters see the same bus bits
  csr_file csr_file_inst (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .ex_csr_i       (ex_csr_i),
    .dbg_csr_i      (dbg_csr_i),
    .trap_i         (trap_i),
    .bus_i          (bus_i),
    .rdata_o        (csr_rdata_o),
    .m_irq_enable_o (m_irq_enable_o),
    .mepc_o         (mepc_o)
  );

  //////////////////////////////
  // Busy tracking
  //////////////////////////////

  // Only the request bit matters for the load-wait case
  busy_tracker busy_tracker_inst (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .busy_i         (busy_i),
    .bus_req_i      (bus_i.req),
    .debug_busy_i   (debug_busy_i),
    .clock_en_req_i (clock_en_req_i),
    .fetch_enable_i (fetch_enable_i),
    .core_busy_o    (core_busy_o),
    .clock_en_o     (clock_en_o),
    .sleeping_o     (sleeping_o)
  );

endmodule

`default_nettype wire

// File: tb/core_shell_model.svh
// Reference model of the CSR shell: machine CSRs, event counters and core-busy register

`ifndef CORE_SHELL_MODEL_SVH
`define CORE_SHELL_MODEL_SVH

// Expected register state
logic       exp_mie;
logic       exp_mpie;
word_t      exp_mepc;
exc_cause_t exp_mcause;
word_t      exp_cnt_load;
word_t      exp_cnt_store;
logic       exp_busy_q;

// Reset values, all zero
task automatic clear_model();
  exp_mie       = 1'b0;
  exp_mpie      = 1'b0;
  exp_mepc      = '0;
  exp_mcause    = '0;
  exp_cnt_load  = '0;
  exp_cnt_store = '0;
  exp_busy_q    = 1'b0;
endtask

// Debug request first, a debug access is a write or a plain read
task automatic merge_request(input ex_csr_req_t ex, input dbg_csr_req_t dbg,
                             output csr_op_e op, output csr_addr_t addr,
                             output word_t data);
  if (dbg.req) begin
    op   = dbg.we ? CSR_OP_WRITE : CSR_OP_NONE;
    addr = dbg.addr;
    data = dbg.wdata;
  end else begin
    op   = ex.op;
    addr = ex.access ? ex.operand_b[11:0] : 12'h000;
    data = ex.operand_a;
  end
endtask

// Expected read data, unknown addresses give zero
function automatic word_t read_model(input csr_addr_t addr);
  word_t r;
  r = '0;
  case (addr)
    `CSR_MSTATUS: begin
      r[`MSTATUS_MIE_BIT]  = exp_mie;
      r[`MSTATUS_MPIE_BIT] = exp_mpie;
    end
    `CSR_MEPC:       r = exp_mepc;
    // Interrupt flag in bit 31
    `CSR_MCAUSE:     r = {exp_mcause[5], 26'b0, exp_mcause[4:0]};
    `CSR_MCNT_LOAD:  r = exp_cnt_load;
    `CSR_MCNT_STORE: r = exp_cnt_store;
    default: ;
  endcase
  return r;
endfunction

// State after one rising edge with the given inputs
task automatic advance_model(input ex_csr_req_t ex, input dbg_csr_req_t dbg,
                             input trap_ctrl_t trap, input data_bus_mon_t bus,
                             input stage_busy_t busy);
  csr_op_e   op;
  csr_addr_t addr;
  word_t     data;
  word_t     old_val;
  word_t     new_val;
  logic      we;
  logic      mie_old;
  logic      mpie_old;
  merge_request(ex, dbg, op, addr, data);
  old_val = read_model(addr);
  case (op)
    CSR_OP_WRITE: new_val = data;
    CSR_OP_SET:   new_val = old_val | data;
    CSR_OP_CLEAR: new_val = old_val & ~data;
    default:      new_val = old_val;
  endcase
  we       = (op != CSR_OP_NONE);
  mie_old  = exp_mie;
  mpie_old = exp_mpie;

  // CSR write, mepc kept halfword aligned
  if (we) begin
    case (addr)
      `CSR_MSTATUS: begin
        exp_mie  = new_val[`MSTATUS_MIE_BIT];
        exp_mpie = new_val[`MSTATUS_MPIE_BIT];
      end
      `CSR_MEPC:   exp_mepc   = {new_val[31:1], 1'b0};
      `CSR_MCAUSE: exp_mcause = {new_val[31], new_val[4:0]};
      default: ;
    endcase
  end

  // Write beats the increment
  if (we && (addr == `CSR_MCNT_LOAD)) begin
    exp_cnt_load = new_val;
  end else if (bus.req && bus.gnt && !bus.we) begin
    exp_cnt_load = exp_cnt_load + 32'd1;
  end
  if (we && (addr == `CSR_MCNT_STORE)) begin
    exp_cnt_store = new_val;
  end else if (bus.req && bus.gnt && bus.we) begin
    exp_cnt_store = exp_cnt_store + 32'd1;
  end

  // Trap save and restore over any write
  if (trap.save_id) begin
    exp_mepc = {trap.pc_id[31:1], 1'b0};
  end else if (trap.save_if) begin
    exp_mepc = {trap.pc_if[31:1], 1'b0};
  end
  if (trap.save_cause) begin
    exp_mcause = trap.cause;
    exp_mpie   = mie_old;
    exp_mie    = 1'b0;
  end
  if (trap.restore_mret) begin
    exp_mie  = mpie_old;
    exp_mpie = 1'b1;
  end

  // Load wait leaves only the fetch side
  exp_busy_q = (busy.load_event && bus.req) ? busy.if_busy
             : (busy.if_busy | busy.ctrl_busy | busy.lsu_busy);
endtask

`endif

// File: tb/core_shell_tb.sv
// Testbench of the core control shell with seeded random stimulus checked against a model

`default_nettype none

`include "core_shell_defs.svh"

module core_shell_tb import core_shell_pkg::*; ();

  localparam int CLK_PERIOD = 4;
  localparam int RST_CYCLES = 16;
  localparam int N_CYCLES   = 4000;
  localparam int MARGIN     = 200;

  logic          clk;
  logic          rst_ni;
  ex_csr_req_t   ex_csr;
  dbg_csr_req_t  dbg_csr;
  trap_ctrl_t    trap;
  data_bus_mon_t bus;
  stage_busy_t   busy;
  logic          debug_busy;
  logic          clock_en_req;
  logic          fetch_enable;
  word_t         csr_rdata_o;
  logic          m_irq_enable_o;
  word_t         mepc_o;
  logic          core_busy_o;
  logic          clock_en_o;
  logic          sleeping_o;
  int            errors;
  int            checks;

  `include "core_shell_model.svh"

  core_shell core_shell_inst (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .ex_csr_i       (ex_csr),
    .dbg_csr_i      (dbg_csr),
    .csr_rdata_o    (csr_rdata_o),
    .trap_i         (trap),
    .m_irq_enable_o (m_irq_enable_o),
    .mepc_o         (mepc_o),
    .bus_i          (bus),
    .busy_i         (busy),
    .debug_busy_i   (debug_busy),
    .clock_en_req_i (clock_en_req),
    .fetch_enable_i (fetch_enable),
    .core_busy_o    (core_busy_o),
    .clock_en_o     (clock_en_o),
    .sleeping_o     (sleeping_o)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  // Seven in eight draws hit a known CSR
  function automatic csr_addr_t pick_addr();
    word_t r;
    r = $urandom;
    case (r[2:0])
      3'd0, 3'd6: return `CSR_MSTATUS;
      3'd1, 3'd7: return `CSR_MEPC;
      3'd2:       return `CSR_MCAUSE;
      3'd3:       return `CSR_MCNT_LOAD;
      3'd4:       return `CSR_MCNT_STORE;
      default:    return r[15:4];
    endcase
  endfunction

  task automatic drive_random();
    word_t r;
    word_t r2;
    word_t rb;
    r  = $urandom;
    r2 = $urandom;
    rb = $urandom;
    // Execute access always carries a real op
    ex_csr.access    = r[0] | r[1];
    ex_csr.op        = ex_csr.access ? csr_op_e'((r[3:2] == 2'b00) ? 2'b01 : r[3:2])
                                     : CSR_OP_NONE;
    ex_csr.operand_a = $urandom;
    ex_csr.operand_b = {rb[31:12], pick_addr()};
    // Debug in about a quarter of the cycles
    dbg_csr.req      = (r[5:4] == 2'b00);
    dbg_csr.we       = r[6];
    dbg_csr.addr     = pick_addr();
    dbg_csr.wdata    = $urandom;
    // Save and restore never together
    trap.save_cause   = (r[10:8] == 3'b000);
    trap.restore_mret = !trap.save_cause && (r[13:11] == 3'b000);
    trap.save_id      = (r[16:14] == 3'b000);
    trap.save_if      = (r[19:17] == 3'b000);
    trap.cause        = r[25:20];
    trap.pc_if        = $urandom;
    trap.pc_id        = $urandom;
    bus               = data_bus_mon_t'(r2[2:0]);
    busy.if_busy      = r2[3] & r2[4];
    busy.ctrl_busy    = r2[5] & r2[6];
    busy.lsu_busy     = r2[7] & r2[8];
    busy.load_event   = r2[9];
    busy.firstfetch   = (r2[12:10] == 3'b000);
    debug_busy        = (r2[15:13] == 3'b000);
    clock_en_req      = (r2[18:16] == 3'b000);
    fetch_enable      = r2[19] | r2[20];
  endtask

  //////////////////////////////
  // Checks
  //////////////////////////////

  task automatic compare_word(input string what, input word_t got, input word_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic compare_bit(input string what, input logic got, input logic exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERROR at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Read data follows the effective address of this cycle
  task automatic check_outputs();
    csr_op_e   op;
    csr_addr_t addr;
    word_t     data;
    logic      busy_exp;
    merge_request(ex_csr, dbg_csr, op, addr, data);
    busy_exp = busy.firstfetch | exp_busy_q;
    compare_word("csr_rdata_o", csr_rdata_o, read_model(addr));
    compare_bit("m_irq_enable_o", m_irq_enable_o, exp_mie);
    compare_word("mepc_o", mepc_o, exp_mepc);
    compare_bit("core_busy_o", core_busy_o, busy_exp);
    compare_bit("clock_en_o", clock_en_o, clock_en_req | busy_exp | debug_busy);
    compare_bit("sleeping_o", sleeping_o, ~fetch_enable & ~busy_exp);
  endtask

  //////////////////////////////
  // Sequence
  //////////////////////////////

  initial begin
    errors       = 0;
    checks       = 0;
    rst_ni       = 1'b0;
    ex_csr       = '0;
    dbg_csr      = '0;
    trap         = '0;
    bus          = '0;
    busy         = '0;
    debug_busy   = 1'b0;
    clock_en_req = 1'b0;
    // Fetch on so every output sits at zero in reset
    fetch_enable = 1'b1;
    void'($urandom(32'haeba_1068));
    clear_model();
    repeat (RST_CYCLES - 1) @(posedge clk);
    #3;
    check_outputs();
    @(posedge clk);
    #1;
    rst_ni = 1'b1;
    // Drive after the edge and check one unit before the next
    for (int i = 0; i < N_CYCLES; i++) begin
      drive_random();
      #2;
      check_outputs();
      advance_model(ex_csr, dbg_csr, trap, bus, busy);
      @(posedge clk);
      #1;
    end
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // Watchdog sized from reset plus the random run
  initial begin
    #((RST_CYCLES + N_CYCLES + MARGIN) * CLK_PERIOD);
    $display("Timeout: the random run did not finish in time");
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+design
+incdir+tb
design/core_shell_pkg.sv
design/perf_counters.sv
design/csr_file.sv
design/busy_tracker.sv
design/core_shell.sv
tb/core_shell_tb.sv

// File: Makefile
# Verilator simulation of the core control shell

VERILATOR ?= verilator
TOP       ?= core_shell_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

.PHONY: sim clean

# Pass only when the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "Everything OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
